//--- logic/bru_macros.svh
/*
 Widths and reset values for the branch resolution path
 Operand and PC widths are assumed equal (RV32I)
 */

`ifndef BRU_MACROS_SVH
`define BRU_MACROS_SVH

// Register value and compare operand width
`define BRU_XLEN 32

// PC and redirect target width
`define BRU_INST_ADDR_WIDTH 32

// Redirect address seen on jump_addr_o out of reset
`define BRU_RESET_PC 32'h0000_0000

`endif // BRU_MACROS_SVH

//--- logic/rv_inst_pkg.sv
/*
 RV32I encoding constants used by the branch decode
 Only control-transfer opcodes and branch funct3 codes
 FENCE and FENCE.I share MISC_MEM and are not told apart
 */

package rv_inst_pkg;

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111; // FENCE family

    // Branch conditions, inst[14:12] under OPC_BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100; // Signed
    localparam logic [2:0] F3_BGE  = 3'b101; // Signed
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // 010 and 011 are reserved in the branch space

endpackage

//--- logic/bru_pkg.sv
/*
 Operation codes carried from decode into the branch unit
 BJP_NONE marks a slot that must not redirect
 */

package bru_pkg;

    // One code per resolved control-transfer kind
    typedef enum logic [3:0] {
        BJP_NONE  = 4'd0, // Not a control transfer
        BJP_JAL   = 4'd1, // Unconditional, pc relative
        BJP_JALR  = 4'd2, // Unconditional, register based
        BJP_BEQ   = 4'd3,
        BJP_BNE   = 4'd4,
        BJP_BLT   = 4'd5,
        BJP_BGE   = 4'd6,
        BJP_BLTU  = 4'd7,
        BJP_BGEU  = 4'd8,
        BJP_FENCE = 4'd9  // Refetch at pc+4
    } bjp_op_e;

    // Codes 10..15 unused

endpackage

//--- logic/bjp_decode.sv
/*
 Decode and operand stage of the branch resolution path
 One instruction per valid_i strobe, no back-pressure
 Interrupt request sampled every cycle beside the instruction
 kill_i empties the stage, dropping both instruction and interrupt
 */

`timescale 1ns/1ps

`include "bru_macros.svh"

module bjp_decode (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            valid_i,
    input  logic [31:0]                     inst_i,
    input  logic [`BRU_INST_ADDR_WIDTH-1:0] pc_i,
    input  logic [`BRU_XLEN-1:0]            rs1_data_i,
    input  logic [`BRU_XLEN-1:0]            rs2_data_i,
    input  logic                            int_assert_i,
    input  logic [`BRU_INST_ADDR_WIDTH-1:0] int_addr_i,
    input  logic                            kill_i,        // Redirect from the stage item
    output bru_pkg::bjp_op_e                op_o,
    output logic                            stage_valid_o,
    output logic                            stage_int_o,
    output logic [`BRU_INST_ADDR_WIDTH-1:0] stage_int_addr_o,
    output logic [`BRU_XLEN-1:0]            cmp_op1_o,
    output logic [`BRU_XLEN-1:0]            cmp_op2_o,
    output logic [`BRU_INST_ADDR_WIDTH-1:0] jump_op1_o,
    output logic [`BRU_INST_ADDR_WIDTH-1:0] jump_op2_o,
    output logic [4:0]                      rd_addr_o,
    output logic [`BRU_XLEN-1:0]            link_addr_o
);
    import rv_inst_pkg::*;
    import bru_pkg::*;

    logic [6:0]                      opcode;
    logic [2:0]                      funct3;
    logic [31:0]                     imm_i;
    logic [31:0]                     imm_j;
    logic [31:0]                     imm_b;
    bjp_op_e                         op_d;
    logic [`BRU_INST_ADDR_WIDTH-1:0] jump_op1_d;
    logic [`BRU_INST_ADDR_WIDTH-1:0] jump_op2_d;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    // Sign-extended immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // Class decode and target operand select
    always_comb begin
        op_d       = BJP_NONE;
        jump_op1_d = pc_i;                         // pc relative unless JALR
        jump_op2_d = `BRU_INST_ADDR_WIDTH'(4);
        case (opcode)
            OPC_JAL: begin
                op_d       = BJP_JAL;
                jump_op2_d = imm_j;
            end
            OPC_JALR: begin
                op_d       = BJP_JALR;
                jump_op1_d = rs1_data_i;           // Bit 0 cleared after the add
                jump_op2_d = imm_i;
            end
            OPC_BRANCH: begin
                jump_op2_d = imm_b;
                case (funct3)
                    F3_BEQ:  op_d = BJP_BEQ;
                    F3_BNE:  op_d = BJP_BNE;
                    F3_BLT:  op_d = BJP_BLT;
                    F3_BGE:  op_d = BJP_BGE;
                    F3_BLTU: op_d = BJP_BLTU;
                    F3_BGEU: op_d = BJP_BGEU;
                    default: op_d = BJP_NONE;      // Reserved codes never branch
                endcase
            end
            OPC_MISC_MEM: op_d = BJP_FENCE;        // Keeps pc+4 operands
            default:      op_d = BJP_NONE;
        endcase
    end

    // Control part of the stage
    always_ff @(posedge clk) begin
        if (rst_i || kill_i) begin
            stage_valid_o <= 1'b0;
            stage_int_o   <= 1'b0;
            op_o          <= BJP_NONE;
        end else begin
            stage_valid_o <= valid_i;
            stage_int_o   <= int_assert_i;         // Independent of valid_i
            op_o          <= op_d;                 // Qualified by stage_valid_o
        end
    end

    // Payload, qualified by the control bits above
    always_ff @(posedge clk) begin
        stage_int_addr_o <= int_addr_i;
        cmp_op1_o        <= rs1_data_i;
        cmp_op2_o        <= rs2_data_i;
        jump_op1_o       <= jump_op1_d;
        jump_op2_o       <= jump_op2_d;
        rd_addr_o        <= inst_i[11:7];
        link_addr_o      <= `BRU_XLEN'(pc_i) + `BRU_XLEN'(4);
    end

endmodule

//--- logic/exu_bru.sv
/*
 Branch unit, purely combinational
 Priority is interrupt, then JAL/JALR/branch, then FENCE refetch
 Targets are not checked for alignment, JALR only clears bit 0
 */

`timescale 1ns/1ps

`include "bru_macros.svh"

module exu_bru (
    input  logic                            stage_valid_i,
    input  bru_pkg::bjp_op_e                op_i,
    input  logic [`BRU_XLEN-1:0]            cmp_op1_i,
    input  logic [`BRU_XLEN-1:0]            cmp_op2_i,
    input  logic [`BRU_INST_ADDR_WIDTH-1:0] jump_op1_i,
    input  logic [`BRU_INST_ADDR_WIDTH-1:0] jump_op2_i,
    input  logic                            stage_int_i,
    input  logic [`BRU_INST_ADDR_WIDTH-1:0] stage_int_addr_i,
    input  logic [4:0]                      rd_addr_i,
    output logic                            jump_flag_o,
    output logic [`BRU_INST_ADDR_WIDTH-1:0] jump_addr_o,
    output logic                            link_we_o
);
    import bru_pkg::*;

    logic                            op_eq;
    logic                            op_ge_s;
    logic                            op_ge_u;
    logic                            cond;
    logic [`BRU_INST_ADDR_WIDTH-1:0] target_sum;
    logic [`BRU_INST_ADDR_WIDTH-1:0] target;

    // Shared comparators
    assign op_eq   = (cmp_op1_i == cmp_op2_i);
    assign op_ge_s = ($signed(cmp_op1_i) >= $signed(cmp_op2_i));
    assign op_ge_u = (cmp_op1_i >= cmp_op2_i);

    // Single target adder for every class
    assign target_sum = jump_op1_i + jump_op2_i;
    assign target     = (op_i == BJP_JALR) ? {target_sum[`BRU_INST_ADDR_WIDTH-1:1], 1'b0}
                                           : target_sum;

    // Branch condition per op
    always_comb begin
        case (op_i)
            BJP_JAL, BJP_JALR: cond = 1'b1;
            BJP_BEQ:           cond = op_eq;
            BJP_BNE:           cond = ~op_eq;
            BJP_BLT:           cond = ~op_ge_s;
            BJP_BGE:           cond = op_ge_s;
            BJP_BLTU:          cond = ~op_ge_u;
            BJP_BGEU:          cond = op_ge_u;
            default:           cond = 1'b0;       // NONE and FENCE
        endcase
    end

    // Redirect priority
    always_comb begin
        jump_flag_o = 1'b0;
        jump_addr_o = '0;
        if (stage_int_i) begin
            jump_flag_o = 1'b1;
            jump_addr_o = stage_int_addr_i;
        end else if (stage_valid_i && cond) begin
            jump_flag_o = 1'b1;
            jump_addr_o = target;
        end else if (stage_valid_i && op_i == BJP_FENCE) begin
            jump_flag_o = 1'b1;                   // Refetch at pc+4
            jump_addr_o = target;
        end
    end

    // Link write only for JAL/JALR, never under interrupt, x0 dropped
    assign link_we_o = stage_valid_i && !stage_int_i && (rd_addr_i != 5'd0) &&
                       (op_i == BJP_JAL || op_i == BJP_JALR);

endmodule

//--- logic/jump_commit.sv
/*
 Output register for redirect and link write-back
 jump_flag_o and rd_we_o are single-cycle pulses
 jump_addr_o holds its last target between jumps
 */

`timescale 1ns/1ps

`include "bru_macros.svh"

module jump_commit (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            jump_flag_i,
    input  logic [`BRU_INST_ADDR_WIDTH-1:0] jump_addr_i,
    input  logic                            link_we_i,
    input  logic [4:0]                      rd_addr_i,
    input  logic [`BRU_XLEN-1:0]            link_addr_i,
    output logic                            jump_flag_o,
    output logic [`BRU_INST_ADDR_WIDTH-1:0] jump_addr_o,
    output logic                            rd_we_o,
    output logic [4:0]                      rd_addr_o,
    output logic [`BRU_XLEN-1:0]            rd_wdata_o
);

    // Redirect side
    always_ff @(posedge clk) begin
        if (rst_i) begin
            jump_flag_o <= 1'b0;
            jump_addr_o <= `BRU_RESET_PC;
        end else begin
            jump_flag_o <= jump_flag_i;           // Pulse, never stretched
            if (jump_flag_i) begin
                jump_addr_o <= jump_addr_i;       // Hold otherwise
            end
        end
    end

    // Write-back strobe
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_we_o <= 1'b0;
        end else begin
            rd_we_o <= link_we_i;
        end
    end

    // Write-back payload, valid with rd_we_o
    always_ff @(posedge clk) begin
        if (link_we_i) begin
            rd_addr_o  <= rd_addr_i;
            rd_wdata_o <= link_addr_i;            // pc+4 of the JAL/JALR
        end
    end

endmodule

//--- logic/bru_top.sv
/*
 Branch and jump resolution path, decode to write-back
 Fixed two-edge latency from valid_i or int_assert_i to outputs
 A taken jump discards the item sampled at the same edge
 */

`timescale 1ns/1ps

`include "bru_macros.svh"

module bru_top (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            valid_i,
    input  logic [31:0]                     inst_i,
    input  logic [`BRU_INST_ADDR_WIDTH-1:0] pc_i,
    input  logic [`BRU_XLEN-1:0]            rs1_data_i,
    input  logic [`BRU_XLEN-1:0]            rs2_data_i,
    input  logic                            int_assert_i,
    input  logic [`BRU_INST_ADDR_WIDTH-1:0] int_addr_i,
    output logic                            jump_flag_o,
    output logic [`BRU_INST_ADDR_WIDTH-1:0] jump_addr_o,
    output logic                            rd_we_o,
    output logic [4:0]                      rd_addr_o,
    output logic [`BRU_XLEN-1:0]            rd_wdata_o
);
    import bru_pkg::*;

    // Stage contents
    bjp_op_e                         op;
    logic                            stage_valid;
    logic                            stage_int;
    logic [`BRU_INST_ADDR_WIDTH-1:0] stage_int_addr;
    logic [`BRU_XLEN-1:0]            cmp_op1;
    logic [`BRU_XLEN-1:0]            cmp_op2;
    logic [`BRU_INST_ADDR_WIDTH-1:0] jump_op1;
    logic [`BRU_INST_ADDR_WIDTH-1:0] jump_op2;
    logic [4:0]                      rd_addr;
    logic [`BRU_XLEN-1:0]            link_addr;

    // Resolution results
    logic                            jump_flag;     // Also the kill
    logic [`BRU_INST_ADDR_WIDTH-1:0] jump_addr;
    logic                            link_we;

    bjp_decode bjp_decode_inst (
        .clk              (clk),
        .rst_i            (rst_i),
        .valid_i          (valid_i),
        .inst_i           (inst_i),
        .pc_i             (pc_i),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .int_assert_i     (int_assert_i),
        .int_addr_i       (int_addr_i),
        .kill_i           (jump_flag),
        .op_o             (op),
        .stage_valid_o    (stage_valid),
        .stage_int_o      (stage_int),
        .stage_int_addr_o (stage_int_addr),
        .cmp_op1_o        (cmp_op1),
        .cmp_op2_o        (cmp_op2),
        .jump_op1_o       (jump_op1),
        .jump_op2_o       (jump_op2),
        .rd_addr_o        (rd_addr),
        .link_addr_o      (link_addr)
    );

    exu_bru exu_bru_inst (
        .stage_valid_i    (stage_valid),
        .op_i             (op),
        .cmp_op1_i        (cmp_op1),
        .cmp_op2_i        (cmp_op2),
        .jump_op1_i       (jump_op1),
        .jump_op2_i       (jump_op2),
        .stage_int_i      (stage_int),
        .stage_int_addr_i (stage_int_addr),
        .rd_addr_i        (rd_addr),
        .jump_flag_o      (jump_flag),
        .jump_addr_o      (jump_addr),
        .link_we_o        (link_we)
    );

    jump_commit jump_commit_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .jump_flag_i (jump_flag),
        .jump_addr_i (jump_addr),
        .link_we_i   (link_we),
        .rd_addr_i   (rd_addr),
        .link_addr_i (link_addr),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o),
        .rd_we_o     (rd_we_o),
        .rd_addr_o   (rd_addr_o),
        .rd_wdata_o  (rd_wdata_o)
    );

endmodule

//--- dv/bru_tb.sv
/*
 Table-driven testbench for bru_top
 Each row is checked two edges after it is sampled
 jump_addr_o is checked every row, against the last taken target
 Random branch rows use seed 70111, an idle row follows each taken one
 */

`timescale 1ns/1ps

`include "bru_macros.svh"

module bru_tb;
    localparam int MAX_ROWS = 128;

    logic                            clk = 1'b0;
    logic                            rst_i;
    logic                            valid_i;
    logic [31:0]                     inst_i;
    logic [`BRU_INST_ADDR_WIDTH-1:0] pc_i;
    logic [`BRU_XLEN-1:0]            rs1_data_i;
    logic [`BRU_XLEN-1:0]            rs2_data_i;
    logic                            int_assert_i;
    logic [`BRU_INST_ADDR_WIDTH-1:0] int_addr_i;
    logic                            jump_flag_o;
    logic [`BRU_INST_ADDR_WIDTH-1:0] jump_addr_o;
    logic                            rd_we_o;
    logic [4:0]                      rd_addr_o;
    logic [`BRU_XLEN-1:0]            rd_wdata_o;

    // Stimulus columns
    logic        tv_valid [MAX_ROWS];
    logic [31:0] tv_inst  [MAX_ROWS];
    logic [31:0] tv_pc    [MAX_ROWS];
    logic [31:0] tv_rs1   [MAX_ROWS];
    logic [31:0] tv_rs2   [MAX_ROWS];
    logic        tv_int   [MAX_ROWS];
    logic [31:0] tv_iaddr [MAX_ROWS];
    // Expected columns
    logic        ex_jump  [MAX_ROWS];
    logic [31:0] ex_addr  [MAX_ROWS];
    logic        ex_we    [MAX_ROWS];
    logic [4:0]  ex_rd    [MAX_ROWS];
    logic [31:0] ex_wdata [MAX_ROWS];

    int          n_rows      = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000000;   // Tightened once the table is built
    int          pass_rows   = 0;
    int          fail_rows   = 0;
    int          row_errors;
    int          seed_val;
    logic [31:0] last_addr;               // Value jump_addr_o must hold

    bru_top bru_top_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o),
        .rd_we_o      (rd_we_o),
        .rd_addr_o    (rd_addr_o),
        .rd_wdata_o   (rd_wdata_o)
    );

    always #10 clk = ~clk;                // 20 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Encoders, register fields fixed to x1 and x2
    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] imm);
        enc_b = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_i(input logic [4:0] rd, input logic [11:0] imm);
        enc_i = {imm, 5'd1, 3'b000, rd, 7'b1100111};
    endfunction

    task automatic add_row(input logic v, input logic [31:0] inst, pc, rs1, rs2,
                           input logic irq, input logic [31:0] iaddr, input logic ej,
                           input logic [31:0] ea, input logic ewe, input logic [4:0] erd,
                           input logic [31:0] ewd);
        tv_valid[n_rows] = v;
        tv_inst[n_rows]  = inst;
        tv_pc[n_rows]    = pc;
        tv_rs1[n_rows]   = rs1;
        tv_rs2[n_rows]   = rs2;
        tv_int[n_rows]   = irq;
        tv_iaddr[n_rows] = iaddr;
        ex_jump[n_rows]  = ej;
        ex_addr[n_rows]  = ea;
        ex_we[n_rows]    = ewe;
        ex_rd[n_rows]    = erd;
        ex_wdata[n_rows] = ewd;
        n_rows++;
    endtask

    task automatic add_idle();
        add_row(0, 32'h0000_0013, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);   // nop, valid low
    endtask

    // Expected branch outcome from the RV32I condition rules
    task automatic ref_branch(input logic [2:0] f3, input logic [31:0] a, b, pc,
                              input logic [12:0] imm, output logic taken,
                              output logic [31:0] target);
        case (f3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            default: taken = (a >= b);    // BGEU
        endcase
        target = pc + {{19{imm[12]}}, imm};
    endtask

    // Mostly random, with the signed and unsigned extremes mixed in
    function automatic logic [31:0] pick_operand();
        case ($urandom % 8)
            0:       pick_operand = 32'h0000_0000;
            1:       pick_operand = 32'hFFFF_FFFF;
            2:       pick_operand = 32'h8000_0000;
            3:       pick_operand = 32'h7FFF_FFFF;
            default: pick_operand = $urandom;
        endcase
    endfunction

    task automatic add_random_branches(input int count);
        logic [2:0]  codes [6];
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [12:0] imm;
        logic        taken;
        logic [31:0] target;
        codes = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int i = 0; i < count; i++) begin
            f3  = codes[$urandom % 6];
            a   = pick_operand();
            b   = (($urandom % 4) == 0) ? a : pick_operand();    // Force some equal pairs
            pc  = $urandom & 32'hFFFF_FFFC;
            imm = $urandom & 13'h1FFE;
            ref_branch(f3, a, b, pc, imm, taken, target);
            add_row(1, enc_b(f3, imm), pc, a, b, 0, 0, taken, target, 0, 0, 0);
            if (taken) begin
                add_idle();               // Keep the next row out of the kill window
            end
        end
    endtask

    task automatic compare_value(input string label, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s %s got 0x%h expected 0x%h", label, name, got, exp);
            row_errors++;
        end
    endtask

    task automatic check_row(input int k);
        string label;
        label      = $sformatf("row %0d", k);
        row_errors = 0;
        if (ex_jump[k]) begin
            last_addr = ex_addr[k];
        end
        compare_value(label, "jump_flag_o", 32'(jump_flag_o), 32'(ex_jump[k]));
        compare_value(label, "jump_addr_o", jump_addr_o, last_addr);
        compare_value(label, "rd_we_o", 32'(rd_we_o), 32'(ex_we[k]));
        if (ex_we[k]) begin
            compare_value(label, "rd_addr_o", 32'(rd_addr_o), 32'(ex_rd[k]));
            compare_value(label, "rd_wdata_o", rd_wdata_o, ex_wdata[k]);
        end
        if (row_errors == 0) begin
            pass_rows++;
            $display("%s passed", label);
        end else begin
            fail_rows++;
            $display("%s failed with %0d mismatches", label, row_errors);
        end
    endtask

    initial begin
        rst_i        = 1'b1;
        valid_i      = 1'b0;
        inst_i       = 32'h0000_0013;
        pc_i         = '0;
        rs1_data_i   = '0;
        rs2_data_i   = '0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        seed_val     = $urandom(70111);
        last_addr    = `BRU_RESET_PC;

        // Branches, not taken then taken, offsets of both signs
        add_row(1, enc_b(3'b000, 13'h0010), 32'h100, 32'd1, 32'd2, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, enc_b(3'b000, 13'h0010), 32'h104, '1, '1, 0, 0, 1, 32'h114, 0, 0, 0);
        add_idle();
        add_row(1, enc_b(3'b001, 13'h1FF0), 32'h200, 32'd5, 32'd5, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, enc_b(3'b001, 13'h1FF0), 32'h204, 0, 32'd1, 0, 0, 1, 32'h1F4, 0, 0, 0);
        add_idle();
        add_row(1, enc_b(3'b100, 13'h0020), 32'h300, 32'h7FFF_FFFF, 32'h8000_0000,
                0, 0, 0, 0, 0, 0, 0);
        add_row(1, enc_b(3'b100, 13'h0020), 32'h304, 32'h8000_0000, 32'h7FFF_FFFF,
                0, 0, 1, 32'h324, 0, 0, 0);
        add_idle();
        add_row(1, enc_b(3'b101, 13'h0008), 32'h400, 32'h8000_0000, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, enc_b(3'b101, 13'h0008), 32'h404, 0, 32'h8000_0000,
                0, 0, 1, 32'h40C, 0, 0, 0);
        add_idle();
        add_row(1, enc_b(3'b110, 13'h0FFE), 32'h500, '1, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, enc_b(3'b110, 13'h0FFE), 32'h504, 0, '1, 0, 0, 1, 32'h1502, 0, 0, 0);
        add_idle();
        add_row(1, enc_b(3'b111, 13'h1000), 32'h600, 32'h7FFF_FFFF, 32'h8000_0000,
                0, 0, 0, 0, 0, 0, 0);
        add_row(1, enc_b(3'b111, 13'h1000), 32'h2604, 32'h8000_0000, 32'h7FFF_FFFF,
                0, 0, 1, 32'h1604, 0, 0, 0);
        add_idle();
        // JAL and JALR, with and without a link register
        add_row(1, enc_j(5'd1, 21'h100), 32'h2000, 0, 0, 0, 0, 1, 32'h2100, 1, 5'd1, 32'h2004);
        add_idle();
        add_row(1, enc_j(5'd0, 21'h1FFFF0), 32'h3000, 0, 0, 0, 0, 1, 32'h2FF0, 0, 0, 0);
        add_idle();
        add_row(1, enc_i(5'd5, 12'h005), 32'h3500, 32'h4000, 0,
                0, 0, 1, 32'h4004, 1, 5'd5, 32'h3504);
        add_idle();
        add_row(1, enc_i(5'd0, 12'hFFF), 32'h3600, 32'h8000_0000, 0,
                0, 0, 1, 32'h7FFF_FFFE, 0, 0, 0);
        add_idle();
        // FENCE refetch, then a plain ADDI
        add_row(1, 32'h0FF0_000F, 32'h3700, 0, 0, 0, 0, 1, 32'h3704, 0, 0, 0);
        add_idle();
        add_row(1, 32'h0010_0093, 32'h3800, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // Interrupt over a taken branch and over JAL, then on its own
        add_row(1, enc_b(3'b000, 13'h0010), 32'h3900, 0, 0, 1, 32'h80, 1, 32'h80, 0, 0, 0);
        add_idle();
        add_row(1, enc_j(5'd1, 21'h100), 32'h3A00, 0, 0, 1, 32'h84, 1, 32'h84, 0, 0, 0);
        add_idle();
        add_row(0, 32'h0000_0013, 0, 0, 0, 1, 32'h90, 1, 32'h90, 0, 0, 0);
        add_idle();
        // Kill window, back to back and two cycles later
        add_row(1, enc_j(5'd2, 21'h40), 32'hA00, 0, 0, 0, 0, 1, 32'hA40, 1, 5'd2, 32'hA04);
        add_row(1, enc_b(3'b000, 13'h0010), 32'hB00, 32'd3, 32'd3, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, enc_j(5'd3, 21'h20), 32'hC00, 0, 0, 0, 0, 1, 32'hC20, 1, 5'd3, 32'hC04);
        add_idle();
        add_row(1, enc_j(5'd0, 21'h8), 32'hD00, 0, 0, 0, 0, 1, 32'hD08, 0, 0, 0);
        add_row(0, 32'h0000_0013, 0, 0, 0, 1, 32'hE0, 0, 0, 0, 0, 0);   // Interrupt killed
        add_idle();
        add_random_branches(20);
        cycle_limit = n_rows + 10;

        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        row_errors = 0;
        compare_value("reset", "jump_flag_o", 32'(jump_flag_o), 32'd0);
        compare_value("reset", "rd_we_o", 32'(rd_we_o), 32'd0);
        compare_value("reset", "jump_addr_o", jump_addr_o, 32'h0);
        if (row_errors == 0) begin
            pass_rows++;
            $display("reset check passed");
        end else begin
            fail_rows++;
            $display("reset check failed with %0d mismatches", row_errors);
        end

        // One row per edge, results checked two edges later
        for (int c = 0; c < n_rows + 2; c++) begin
            @(posedge clk);
            if (c < n_rows) begin
                valid_i      <= tv_valid[c];
                inst_i       <= tv_inst[c];
                pc_i         <= tv_pc[c];
                rs1_data_i   <= tv_rs1[c];
                rs2_data_i   <= tv_rs2[c];
                int_assert_i <= tv_int[c];
                int_addr_i   <= tv_iaddr[c];
            end else begin
                valid_i      <= 1'b0;
                int_assert_i <= 1'b0;
            end
            @(negedge clk);
            if (c >= 2) begin
                check_row(c - 2);
            end
        end

        $display("Checks passed: %0d, failed: %0d", pass_rows, fail_rows);
        if (fail_rows == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+logic
logic/rv_inst_pkg.sv
logic/bru_pkg.sv
logic/bjp_decode.sv
logic/exu_bru.sv
logic/jump_commit.sv
logic/bru_top.sv
dv/bru_tb.sv

//--- Bender.yml
package:
  name: bru

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_inst_pkg.sv
      - logic/bru_pkg.sv
      - logic/bjp_decode.sv
      - logic/exu_bru.sv
      - logic/jump_commit.sv
      - logic/bru_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/bru_tb.sv
